/* source/wb_pkg.sv */
package wb_pkg;

	// ****************************************
	// Wishbone classic bus widths
	// ****************************************

	// Byte address width seen by the slave
	localparam int wb_adr_w = 4;

	// Data bus width
	localparam int wb_dat_w = 32;

	// ****************************************
	// Slave handshake states
	// ****************************************

	// Idle waits for cyc and stb, ack holds the one-cycle acknowledge
	typedef enum logic
	{
		st_idle = 1'b0,
		st_ack  = 1'b1
	} wb_state_e;

endpackage

/* source/capture_pkg.sv */
package capture_pkg;

	// ****************************************
	// Sample path sizes
	// ****************************************

	// Width of one captured sample
	localparam int smp_w = 16;

	// Buffer depth, kept a power of two so pointers wrap on their own
	localparam int fifo_depth = 8;
	localparam int ptr_w = $clog2(fifo_depth);

	// Count has to reach fifo_depth, so one bit wider than a pointer
	localparam int cnt_w = 4;

	// Rate divider field width
	localparam int div_w = 8;

	// Fixed seed and taps for x^16+x^14+x^13+x^11+1
	localparam logic [smp_w-1:0] lfsr_seed = 16'hACE1;
	localparam logic [smp_w-1:0] lfsr_taps = 16'hB400;

	// ****************************************
	// Register map
	// ****************************************

	typedef enum logic [3:0]
	{
		ctrl_addr   = 4'h0,
		status_addr = 4'h4,
		data_addr   = 4'h8
	} reg_addr_e;

	// CTRL fields
	localparam int ctrl_en_bit  = 0;
	localparam int ctrl_clr_bit = 1;
	localparam int ctrl_div_lsb = 8;

	// STATUS fields, count sits in bits 3:0
	localparam int st_empty_bit = 4;
	localparam int st_full_bit  = 5;
	localparam int st_ovf_bit   = 6;

endpackage

/* source/sample_source.sv */
`timescale 1ns/1ps

module sample_source
(
	input  logic                          rvx_port_10,
	input  logic                          rvx_port_02,
	input  logic                          enable,
	input  logic                          clear,
	input  logic                          full,
	input  logic [capture_pkg::div_w-1:0] divider,
	output logic                          push,
	output logic                          drop,
	output logic [capture_pkg::smp_w-1:0] push_data
);

	import capture_pkg::*;

	// Enabled cycles seen since the last emission
	logic [div_w-1:0] div_cnt;

	// Fibonacci LFSR state
	logic [smp_w-1:0] lfsr;
	logic             feedback;

	// One emission every divider+1 enabled cycles
	// Suppressed while clear restarts the whole path
	logic             emit;

	// ****************************************
	// Rate divider
	// ****************************************

	// Greater-or-equal so a smaller divider written mid-count still fires
	assign emit = enable & ~clear & (div_cnt >= divider);

	always_ff @(posedge rvx_port_10 or negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			div_cnt <= '0;
		else if (clear)
			div_cnt <= '0;
		else if (emit)
			div_cnt <= '0;
		else if (enable)
			div_cnt <= div_cnt + 1'b1;
	end

	// ****************************************
	// Sample generator
	// ****************************************

	// XOR of the tapped bits enters at bit 0
	assign feedback = ^(lfsr & lfsr_taps);

	// Advances on every emission whether pushed or dropped
	always_ff @(posedge rvx_port_10 or negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			lfsr <= lfsr_seed;
		else if (clear)
			lfsr <= lfsr_seed;
		else if (emit)
			lfsr <= {lfsr[smp_w-2:0], feedback};
	end

	// Current word goes out before the shift
	assign push_data = lfsr;

	// Full buffer turns the emission into a drop
	assign push = emit & ~full;
	assign drop = emit & full;

	// Seed and taps keep the register out of the all-zero lock-up state
	a_lfsr_nonzero: assert property (
		@(posedge rvx_port_10) disable iff (!rvx_port_02)
		lfsr != '0
	);

endmodule

/* source/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo
(
	input  logic                          rvx_port_10,
	input  logic                          rvx_port_02,
	input  logic                          push,
	input  logic                          pop,
	input  logic                          clear,
	input  logic [capture_pkg::smp_w-1:0] push_data,
	output logic [capture_pkg::smp_w-1:0] rd_data,
	output logic [capture_pkg::cnt_w-1:0] count,
	output logic                          full,
	output logic                          empty
);

	import capture_pkg::*;

	// Sample storage
	logic [smp_w-1:0] mem [fifo_depth];

	// Circular pointers
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;

	// Qualified requests
	logic             wr_en;
	logic             rd_en;

	assign wr_en = push & ~full;
	assign rd_en = pop & ~empty;

	// ****************************************
	// Storage write
	// ****************************************

	always_ff @(posedge rvx_port_10)
	begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
	end

	// First word falls through, visible the cycle after its push
	assign rd_data = mem[rd_ptr];

	// ****************************************
	// Pointers and occupancy
	// ****************************************

	always_ff @(posedge rvx_port_10 or negedge rvx_port_02)
	begin
		if (!rvx_port_02)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full  = (count == cnt_w'(fifo_depth));
	assign empty = (count == '0);

	// The source has to turn a full buffer into a drop
	a_no_push_full: assert property (
		@(posedge rvx_port_10) disable iff (!rvx_port_02)
		push |-> !full
	);

endmodule

/* source/csr_slave.sv */
`timescale 1ns/1ps

module csr_slave
(
	input  logic                          rvx_port_10,
	input  logic                          rvx_port_02,

	// Wishbone classic slave
	input  logic                          cyc,
	input  logic                          stb,
	input  logic                          we,
	input  logic [wb_pkg::wb_adr_w-1:0]   adr,
	input  logic [wb_pkg::wb_dat_w-1:0]   dat_w,
	output logic [wb_pkg::wb_dat_w-1:0]   dat_r,
	output logic                          ack,

	// Control towards the source and the buffer
	output logic                          enable,
	output logic [capture_pkg::div_w-1:0] divider,
	output logic                          clear,
	output logic                          pop,

	// Buffer state and sample
	input  logic [capture_pkg::smp_w-1:0] rd_data,
	input  logic [capture_pkg::cnt_w-1:0] count,
	input  logic                          full,
	input  logic                          empty,
	input  logic                          drop
);

	import wb_pkg::*;
	import capture_pkg::*;

	wb_state_e           state;

	// Request accepted in this cycle
	logic                req;
	reg_addr_e           addr;

	// Sticky drop flag
	logic                ovf;

	// Read value chosen by the decoder
	logic [wb_dat_w-1:0] rd_word;

	assign addr = reg_addr_e'(adr);
	assign req  = cyc & stb & (state == st_idle);

	// ****************************************
	// Bus handshake
	// ****************************************

	// Ack lasts one cycle, then the slave waits for the next request
	always_ff @(posedge rvx_port_10 or negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			state <= st_idle;
		else if (state == st_ack)
			state <= st_idle;
		else if (req)
			state <= st_ack;
	end

	assign ack = (state == st_ack);

	// ****************************************
	// Read decode
	// ****************************************

	always_comb
	begin
		rd_word = '0;
		case (addr)
			ctrl_addr:
			begin
				rd_word[ctrl_en_bit] = enable;
				rd_word[ctrl_div_lsb +: div_w] = divider;
			end
			status_addr:
			begin
				rd_word[cnt_w-1:0]   = count;
				rd_word[st_empty_bit] = empty;
				rd_word[st_full_bit]  = full;
				rd_word[st_ovf_bit]   = ovf;
			end
			data_addr:
			begin
				// Empty buffer reads as zero
				if (!empty)
					rd_word[smp_w-1:0] = rd_data;
			end
			default:
			begin
				rd_word = '0;
			end
		endcase
	end

	// Captured with the request, held through the ack cycle
	always_ff @(posedge rvx_port_10)
	begin
		if (req)
			dat_r <= we ? '0 : rd_word;
	end

	// ****************************************
	// Control register
	// ****************************************

	// Write lands in the ack cycle; clear is a one-cycle pulse
	always_ff @(posedge rvx_port_10 or negedge rvx_port_02)
	begin
		if (!rvx_port_02)
		begin
			enable  <= 1'b0;
			divider <= '0;
			clear   <= 1'b0;
		end
		else
		begin
			clear <= 1'b0;
			if (req && we && (addr == ctrl_addr))
			begin
				enable  <= dat_w[ctrl_en_bit];
				divider <= dat_w[ctrl_div_lsb +: div_w];
				clear   <= dat_w[ctrl_clr_bit];
			end
		end
	end

	// DATA read pops in the ack cycle, only with a word present
	always_ff @(posedge rvx_port_10 or negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			pop <= 1'b0;
		else
			pop <= req & ~we & (addr == data_addr) & ~empty;
	end

	// Overflow stays set until the next clear
	always_ff @(posedge rvx_port_10 or negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			ovf <= 1'b0;
		else if (clear)
			ovf <= 1'b0;
		else if (drop)
			ovf <= 1'b1;
	end

	// Ack rises only one cycle after a sampled request
	a_ack_after_req: assert property (
		@(posedge rvx_port_10) disable iff (!rvx_port_02)
		$rose(ack) |-> $past(cyc && stb)
	);

	// Pop issued against the buffer's own empty flag
	a_no_pop_empty: assert property (
		@(posedge rvx_port_10) disable iff (!rvx_port_02)
		pop |-> !empty
	);

endmodule

/* source/capture_top.sv */
`timescale 1ns/1ps

module capture_top
(
	input  logic                        rvx_port_10,
	input  logic                        rvx_port_02,
	input  logic                        cyc,
	input  logic                        stb,
	input  logic                        we,
	input  logic [wb_pkg::wb_adr_w-1:0] adr,
	input  logic [wb_pkg::wb_dat_w-1:0] dat_w,
	output logic [wb_pkg::wb_dat_w-1:0] dat_r,
	output logic                        ack
);

	import capture_pkg::*;

	// Control from the register slave
	logic             enable;
	logic [div_w-1:0] divider;
	logic             clear;
	logic             pop;

	// Source to buffer
	logic             push;
	logic             drop;
	logic [smp_w-1:0] push_data;

	// Buffer state
	logic [smp_w-1:0] rd_data;
	logic [cnt_w-1:0] count;
	logic             full;
	logic             empty;

	// ****************************************
	// Register slave
	// ****************************************

	csr_slave i_csr
	(
		.rvx_port_10 (rvx_port_10),
		.rvx_port_02 (rvx_port_02),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.dat_w       (dat_w),
		.dat_r       (dat_r),
		.ack         (ack),
		.enable      (enable),
		.divider     (divider),
		.clear       (clear),
		.pop         (pop),
		.rd_data     (rd_data),
		.count       (count),
		.full        (full),
		.empty       (empty),
		.drop        (drop)
	);

	// ****************************************
	// Sample path
	// ****************************************

	sample_source i_source
	(
		.rvx_port_10 (rvx_port_10),
		.rvx_port_02 (rvx_port_02),
		.enable      (enable),
		.clear       (clear),
		.full        (full),
		.divider     (divider),
		.push        (push),
		.drop        (drop),
		.push_data   (push_data)
	);

	sample_fifo i_fifo
	(
		.rvx_port_10 (rvx_port_10),
		.rvx_port_02 (rvx_port_02),
		.push        (push),
		.pop         (pop),
		.clear       (clear),
		.push_data   (push_data),
		.rd_data     (rd_data),
		.count       (count),
		.full        (full),
		.empty       (empty)
	);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
	output logic rvx_port_10,
	output logic rvx_port_02
);

	// 4 ns clock period
	localparam int half_period  = 2;
	localparam int reset_cycles = 16;

	initial
	begin
		rvx_port_10 = 1'b0;
		forever
			#half_period rvx_port_10 = ~rvx_port_10;
	end

	// Reset held low for 16 cycles, released away from the rising edge
	initial
	begin
		rvx_port_02 = 1'b0;
		repeat (reset_cycles) @(posedge rvx_port_10);
		@(negedge rvx_port_10);
		rvx_port_02 = 1'b1;
	end

endmodule

/* bench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
(
	input  logic                        rvx_port_10,
	input  logic                        rvx_port_02,
	input  logic                        ack,
	input  logic [wb_pkg::wb_dat_w-1:0] dat_r,
	input  logic                        check_en,
	input  logic [wb_pkg::wb_dat_w-1:0] exp_data,
	input  logic [wb_pkg::wb_dat_w-1:0] exp_mask,
	input  logic [8*24-1:0]             test_name,
	output int                          pass_cnt,
	output int                          fail_cnt
);

	import wb_pkg::*;

	// Masked views of the returned and the expected word
	logic [wb_dat_w-1:0] got;
	logic [wb_dat_w-1:0] want;

	initial
	begin
		pass_cnt = 0;
		fail_cnt = 0;
	end

	// ****************************************
	// Read data compare
	// ****************************************

	// Ack and dat_r only move on the rising edge
	// Falling edge sees them settled
	always @(negedge rvx_port_10)
	begin
		if (rvx_port_02 && ack && check_en)
		begin
			got  = dat_r & exp_mask;
			want = exp_data & exp_mask;
			if (got === want)
			begin
				pass_cnt = pass_cnt + 1;
				$display("Test %0s passed, read 0x%08h", test_name, dat_r);
			end
			else
			begin
				fail_cnt = fail_cnt + 1;
				// Actual word shown as returned by the DUT
				$display("Mismatch in test %0s: expected 0x%08h, actual 0x%08h",
					test_name, want, dat_r);
			end
		end
	end

endmodule

/* bench/tb_capture.sv */
`timescale 1ns/1ps

module tb_capture;

	import wb_pkg::*;
	import capture_pkg::*;

	localparam int clk_period = 4;
	localparam int ack_limit  = 16;
	localparam int poll_limit = 64;
	localparam int name_w     = 8 * 24;

	logic                rvx_port_10;
	logic                rvx_port_02;

	// Wishbone master side
	logic                cyc;
	logic                stb;
	logic                we;
	logic [wb_adr_w-1:0] adr;
	logic [wb_dat_w-1:0] dat_w;
	logic [wb_dat_w-1:0] dat_r;
	logic                ack;

	// Expected result seen by the checker
	logic                check_en;
	logic [wb_dat_w-1:0] exp_data;
	logic [wb_dat_w-1:0] exp_mask;
	logic [name_w-1:0]   test_name;
	int                  pass_cnt;
	int                  fail_cnt;

	// Staged copy handed over with the next request
	logic [wb_dat_w-1:0] next_exp;
	logic [wb_dat_w-1:0] next_mask;
	logic [name_w-1:0]   next_name;

	// Test list from the stimulus file
	logic [7:0]          op_q [$];
	logic [name_w-1:0]   name_q [$];
	logic [wb_adr_w-1:0] adr_q [$];
	logic [wb_dat_w-1:0] data_q [$];
	logic [wb_dat_w-1:0] exp_q [$];
	logic [wb_dat_w-1:0] mask_q [$];

	int                  bench_fails = 0;
	int                  run_cycles = 0;

	// ****************************************
	// Clock, DUT and checker
	// ****************************************

	tb_clock i_clock
	(
		.rvx_port_10 (rvx_port_10),
		.rvx_port_02 (rvx_port_02)
	);

	capture_top i_dut
	(
		.rvx_port_10 (rvx_port_10),
		.rvx_port_02 (rvx_port_02),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.dat_w       (dat_w),
		.dat_r       (dat_r),
		.ack         (ack)
	);

	tb_checker i_checker
	(
		.rvx_port_10 (rvx_port_10),
		.rvx_port_02 (rvx_port_02),
		.ack         (ack),
		.dat_r       (dat_r),
		.check_en    (check_en),
		.exp_data    (exp_data),
		.exp_mask    (exp_mask),
		.test_name   (test_name),
		.pass_cnt    (pass_cnt),
		.fail_cnt    (fail_cnt)
	);

	// ****************************************
	// Stimulus file and bus tasks
	// ****************************************

	// Fills the test list and sums 64 cycles per line plus the idles
	task automatic load_tests(output int total_cycles);
		int                  fd;
		int                  got;
		int                  fields;
		logic [8*128-1:0]    line;
		logic [7:0]          op;
		logic [name_w-1:0]   name;
		logic [wb_dat_w-1:0] a;
		logic [wb_dat_w-1:0] d;
		logic [wb_dat_w-1:0] e;
		logic [wb_dat_w-1:0] m;
		begin
			total_cycles = 16;
			fd = $fopen("bench/capture_stimulus.txt", "r");
			if (fd != 0)
			begin
				while (!$feof(fd))
				begin
					line = '0;
					got = $fgets(line, fd);
					fields = $sscanf(line, "%s %s %h %h %h %h", op, name, a, d, e, m);
					// Comment and blank lines fall short of six fields
					if (got > 0 && fields == 6 &&
						(op == "W" || op == "R" || op == "I" || op == "P"))
					begin
						op_q.push_back(op);
						name_q.push_back(name);
						adr_q.push_back(a[wb_adr_w-1:0]);
						data_q.push_back(d);
						exp_q.push_back(e);
						mask_q.push_back(m);
						total_cycles += 64;
						if (op == "I")
							total_cycles += d;
					end
				end
				$fclose(fd);
			end
		end
	endtask

	// One classic cycle with the request held until ack or the limit
	task automatic bus_cycle(input logic write, input logic [wb_adr_w-1:0] addr,
		input logic [wb_dat_w-1:0] wdata, input logic check,
		output logic [wb_dat_w-1:0] rdata, output logic ok);
		int waited;
		begin
			@(negedge rvx_port_10);
			check_en  = check;
			exp_data  = next_exp;
			exp_mask  = next_mask;
			test_name = next_name;
			cyc       = 1'b1;
			stb       = 1'b1;
			we        = write;
			adr       = addr;
			dat_w     = wdata;
			waited    = 0;
			rdata     = '0;
			ok        = 1'b0;
			while (!ok && waited < ack_limit)
			begin
				@(negedge rvx_port_10);
				waited++;
				if (ack)
				begin
					ok    = 1'b1;
					rdata = dat_r;
				end
			end
			cyc = 1'b0;
			stb = 1'b0;
			we  = 1'b0;
		end
	endtask

	task automatic report_no_ack(input logic [name_w-1:0] name);
		begin
			$display("Test %0s: no acknowledge within %0d cycles", name, ack_limit);
			bench_fails++;
		end
	endtask

	// Runs one line of the list after a short random gap
	task automatic run_line(input int i);
		logic [wb_dat_w-1:0] rdata;
		logic                ok;
		logic                empty_seen;
		int                  polls;
		begin
			repeat ($urandom % 4) @(negedge rvx_port_10);
			next_name = name_q[i];
			next_exp  = exp_q[i];
			next_mask = mask_q[i];
			case (op_q[i])
				"W":
				begin
					bus_cycle(1'b1, adr_q[i], data_q[i], 1'b0, rdata, ok);
					if (ok)
						$display("Test %0s: write done", name_q[i]);
					else
						report_no_ack(name_q[i]);
				end
				"R":
				begin
					bus_cycle(1'b0, adr_q[i], '0, 1'b1, rdata, ok);
					if (!ok)
						report_no_ack(name_q[i]);
				end
				"I":
				begin
					repeat (data_q[i]) @(negedge rvx_port_10);
					$display("Test %0s: idle %0d cycles done", name_q[i], data_q[i]);
				end
				default:
				begin
					// Poll STATUS until a word is there and then read it
					polls      = 0;
					ok         = 1'b1;
					empty_seen = 1'b1;
					while (ok && empty_seen && polls < poll_limit)
					begin
						bus_cycle(1'b0, status_addr, '0, 1'b0, rdata, ok);
						empty_seen = rdata[st_empty_bit];
						polls++;
					end
					if (!ok)
						report_no_ack(name_q[i]);
					else if (empty_seen)
					begin
						$display("Test %0s: FIFO still empty after %0d status reads",
							name_q[i], polls);
						bench_fails++;
					end
					else
					begin
						bus_cycle(1'b0, adr_q[i], '0, 1'b1, rdata, ok);
						if (!ok)
							report_no_ack(name_q[i]);
					end
				end
			endcase
		end
	endtask

	// ****************************************
	// Main sequence
	// ****************************************

	initial
	begin
		cyc       = 1'b0;
		stb       = 1'b0;
		we        = 1'b0;
		adr       = '0;
		dat_w     = '0;
		check_en  = 1'b0;
		exp_data  = '0;
		exp_mask  = '0;
		test_name = '0;
		next_exp  = '0;
		next_mask = '0;
		next_name = '0;
		void'($urandom(92));
		load_tests(run_cycles);
		if (op_q.size() == 0)
		begin
			$display("Stimulus file missing or holds no tests");
			bench_fails++;
		end
		wait (rvx_port_02 === 1'b1);
		@(negedge rvx_port_10);
		foreach (op_q[i])
			run_line(i);
		repeat (2) @(negedge rvx_port_10);
		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt + bench_fails);
		if (fail_cnt + bench_fails == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog sized from the test list
	initial
	begin
		wait (run_cycles > 0);
		#(run_cycles * clk_period);
		$display("Watchdog: run went past %0d cycles and was stopped", run_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* bench/capture_stimulus.txt */
# Columns: op name addr data expect mask, numbers in hex
# Ops: W write, R read, I idle for data cycles, P poll STATUS then read
R rst_ctrl        0 0    0    ffffffff
R rst_status      4 0    10   ffffffff
W ctrl_wr_clr     0 5a02 0    0
R ctrl_rd_clr     0 0    5a00 ffffffff
W ctrl_wr_en      0 c301 0    0
R ctrl_rd_en      0 0    c301 ffffffff
W ctrl_wr_off     0 0002 0    0
R status_off      4 0    10   ffffffff
W status_wr       4 ff   0    0
R status_ro       4 0    10   ffffffff
W data_wr         8 1234 0    0
R ctrl_after_wr   0 0    0    ffffffff
R data_empty      8 0    0    ffffffff
R status_empty    4 0    10   ffffffff
W unmapped_wr     c ffff 0    0
R unmapped_rd     c 0    0    ffffffff
R ctrl_unmapped   0 0    0    ffffffff
W fill_start      0 0301 0    0
I fill_wait       0 c8   0    0
W fill_stop       0 0300 0    0
R fill_status     4 0    68   ffffffff
R fill_d0         8 0    ace1 ffffffff
R fill_d1         8 0    59c3 ffffffff
R fill_d2         8 0    b387 ffffffff
R fill_d3         8 0    670f ffffffff
R fill_d4         8 0    ce1e ffffffff
R fill_d5         8 0    9c3c ffffffff
R fill_d6         8 0    3879 ffffffff
R fill_d7         8 0    70f2 ffffffff
R drain_status    4 0    50   ffffffff
W clr_ovf         0 0002 0    0
R clr_status      4 0    10   ffffffff
W poll_start      0 2001 0    0
P poll_d0         8 0    ace1 ffffffff
P poll_d1         8 0    59c3 ffffffff
P poll_d2         8 0    b387 ffffffff
P poll_d3         8 0    670f ffffffff
W poll_stop       0 0002 0    0
R end_status      4 0    10   ffffffff

/* tb.f */
source/wb_pkg.sv
source/capture_pkg.sv
source/sample_source.sv
source/sample_fifo.sv
source/csr_slave.sv
source/capture_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_capture.sv

/* Bender.yml */
package:
  name: sample_capture

sources:
  # RTL, packages first
  - source/wb_pkg.sv
  - source/capture_pkg.sv
  - source/sample_source.sv
  - source/sample_fifo.sv
  - source/csr_slave.sv
  - source/capture_top.sv
  # Testbench
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_checker.sv
      - bench/tb_capture.sv
